/* enc_cfg_pkg.sv */
// Width, lane and latency constants for the wide priority encoder
package enc_cfg_pkg;

  // Full request word
  localparam int REQ_W = 32;

  // Lane split
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = REQ_W / LANE_W;

  // Index within one lane
  localparam int LANE_IDX_W = $clog2(LANE_W);

  // Lane number within the global index
  localparam int LANE_SEL_W = $clog2(NUM_LANES);

  // Global index is lane number on top of lane index
  localparam int GIDX_W = LANE_SEL_W + LANE_IDX_W;

  // Register stages from valid_in to valid_out
  //   mask stage 1, lane encoder 3, merge 1
  localparam int PIPE_LAT = 5;

endpackage

/* enc_types_pkg.sv */
// Global index union with its flat and lane/bit views
package enc_types_pkg;

  // Lane number sits above the bit position
  typedef struct packed {
    logic [enc_cfg_pkg::LANE_SEL_W-1:0] lane_sel;
    logic [enc_cfg_pkg::LANE_IDX_W-1:0] bit_sel;
  } lane_bit_s;

  // Same 5-bit word, read as a number or as lane plus bit
  typedef union packed {
    logic [enc_cfg_pkg::GIDX_W-1:0] flat;
    lane_bit_s                      parts;
  } global_index_u;

endpackage

/* req_mask_stage.sv */
// Enable mask register and masked request capture stage
`timescale 1ns/1ps

module req_mask_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [enc_cfg_pkg::REQ_W-1:0] req,
  input  logic                          dir,
  input  logic                          valid_in,
  input  logic                          mask_wr,
  input  logic [enc_cfg_pkg::REQ_W-1:0] mask_data,
  output logic [enc_cfg_pkg::REQ_W-1:0] masked_req,
  output logic                          dir_q,
  output logic                          valid_q
);

  import enc_cfg_pkg::*;

  // Enable mask, all bits enabled out of reset
  logic [REQ_W-1:0] mask;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mask <= '1;
    end else if (mask_wr) begin
      mask <= mask_data;
    end
  end

  // Capture stage
  // A request on the mask_wr edge still sees the old mask
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      masked_req <= '0;
      dir_q      <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      masked_req <= req & mask;
      dir_q      <= dir;
      valid_q    <= valid_in;
    end
  end

endmodule

/* lane_prio_enc.sv */
// Three-stage LSB/MSB-first priority encoder for one lane
`timescale 1ns/1ps

module lane_prio_enc (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               dir,
  input  logic                               valid_in,
  input  logic [enc_cfg_pkg::LANE_W-1:0]     req,
  output logic [enc_cfg_pkg::LANE_IDX_W-1:0] index,
  output logic                               hit,
  output logic                               dir_out,
  output logic                               valid_out
);

  import enc_cfg_pkg::*;

  // Stage 1 registers
  logic [LANE_W-1:0] req_s1;
  logic              dir_s1;
  logic              valid_s1;

  // One-hot winners and their binary form, from stage 1
  logic [LANE_W-1:0]     lo_oh;
  logic [LANE_W-1:0]     hi_oh;
  logic [LANE_IDX_W-1:0] lo_bin;
  logic [LANE_IDX_W-1:0] hi_bin;

  // Stage 2 registers
  logic [LANE_IDX_W-1:0] lo_idx_s2;
  logic [LANE_IDX_W-1:0] hi_idx_s2;
  logic                  any_s2;
  logic                  dir_s2;
  logic                  valid_s2;

  // Stage 1: capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_s1   <= '0;
      dir_s1   <= 1'b0;
      valid_s1 <= 1'b0;
    end else begin
      req_s1   <= req;
      dir_s1   <= dir;
      valid_s1 <= valid_in;
    end
  end

  // Isolate lowest and highest set bit, then one-hot to binary
  always_comb begin
    lo_oh  = req_s1 & (~req_s1 + 1'b1);
    hi_oh  = '0;
    lo_bin = '0;
    hi_bin = '0;
    // Later set bits overwrite earlier ones, leaving the top one
    for (int i = 0; i < LANE_W; i++) begin
      if (req_s1[i]) begin
        hi_oh    = '0;
        hi_oh[i] = 1'b1;
      end
    end
    for (int i = 0; i < LANE_W; i++) begin
      if (lo_oh[i]) lo_bin |= LANE_IDX_W'(i);
      if (hi_oh[i]) hi_bin |= LANE_IDX_W'(i);
    end
  end

  // Stage 2: resolve
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lo_idx_s2 <= '0;
      hi_idx_s2 <= '0;
      any_s2    <= 1'b0;
      dir_s2    <= 1'b0;
      valid_s2  <= 1'b0;
    end else begin
      lo_idx_s2 <= lo_bin;
      hi_idx_s2 <= hi_bin;
      any_s2    <= |req_s1;
      dir_s2    <= dir_s1;
      valid_s2  <= valid_s1;
    end
  end

  // Stage 3: select by direction, hold between valid results
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index     <= '0;
      hit       <= 1'b0;
      dir_out   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      dir_out   <= dir_s2;
      valid_out <= valid_s2;
      if (valid_s2) begin
        index <= dir_s2 ? hi_idx_s2 : lo_idx_s2;
        hit   <= any_s2;
      end
    end
  end

endmodule

/* lane_result_merge.sv */
// Lane result merge forming the registered global index and hit
`timescale 1ns/1ps

module lane_result_merge (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [enc_cfg_pkg::NUM_LANES-1:0][enc_cfg_pkg::LANE_IDX_W-1:0] lane_index,
  input  logic [enc_cfg_pkg::NUM_LANES-1:0]   lane_hit,
  input  logic                                dir,
  input  logic                                valid_in,
  output enc_types_pkg::global_index_u        index,
  output logic                                hit,
  output logic                                valid_out
);

  import enc_cfg_pkg::*;
  import enc_types_pkg::*;

  // Winning lane and the index built from it
  logic [LANE_SEL_W-1:0] win_lane;
  logic                  found;
  global_index_u         index_d;

  // LSB-first keeps the first hit lane, MSB-first keeps the last
  always_comb begin
    win_lane = '0;
    found    = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (lane_hit[k] && (!found || dir)) begin
        win_lane = LANE_SEL_W'(k);
        found    = 1'b1;
      end
    end
    index_d.parts.lane_sel = win_lane;
    index_d.parts.bit_sel  = found ? lane_index[win_lane] : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index     <= '0;
      hit       <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
      if (valid_in) begin
        index <= index_d;
        hit   <= |lane_hit;
      end
    end
  end

endmodule

/* wide_prio_enc.sv */
// Top level: mask stage, lane encoder array and lane merge
`timescale 1ns/1ps

module wide_prio_enc (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [enc_cfg_pkg::REQ_W-1:0] req,
  input  logic                          dir,
  input  logic                          valid_in,
  input  logic                          mask_wr,
  input  logic [enc_cfg_pkg::REQ_W-1:0] mask_data,
  output enc_types_pkg::global_index_u  index,
  output logic                          hit,
  output logic                          valid_out
);

  import enc_cfg_pkg::*;

  // Mask stage outputs
  logic [REQ_W-1:0] masked_req;
  logic             dir_q;
  logic             valid_q;

  // Per-lane results
  logic [NUM_LANES-1:0][LANE_IDX_W-1:0] lane_index;
  logic [NUM_LANES-1:0]                 lane_hit;
  logic [NUM_LANES-1:0]                 lane_dir;
  logic [NUM_LANES-1:0]                 lane_valid;

  req_mask_stage u_mask (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .dir        (dir),
    .valid_in   (valid_in),
    .mask_wr    (mask_wr),
    .mask_data  (mask_data),
    .masked_req (masked_req),
    .dir_q      (dir_q),
    .valid_q    (valid_q)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    lane_prio_enc u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .dir       (dir_q),
      .valid_in  (valid_q),
      .req       (masked_req[k*LANE_W +: LANE_W]),
      .index     (lane_index[k]),
      .hit       (lane_hit[k]),
      .dir_out   (lane_dir[k]),
      .valid_out (lane_valid[k])
    );
  end

  // All lanes carry the same dir and valid, lane 0 feeds the merge
  lane_result_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_index (lane_index),
    .lane_hit   (lane_hit),
    .dir        (lane_dir[0]),
    .valid_in   (lane_valid[0]),
    .index      (index),
    .hit        (hit),
    .valid_out  (valid_out)
  );

endmodule

/* wide_prio_enc_tb.sv */
// Testbench for wide_prio_enc with reference queue, assertions, per-test report and timeout
`timescale 1ns/1ps

module wide_prio_enc_tb;

  import enc_cfg_pkg::*;
  import enc_types_pkg::*;

  // Test lengths in cycles
  localparam int RESET_CYC   = 15;
  localparam int N_DIRECTED  = 10;
  localparam int N_RAND      = 20;
  localparam int MASK_CYC    = 24;
  localparam int N_PIPE      = 80;
  localparam int DRAIN_CYC   = PIPE_LAT + 4;
  localparam int TEST_CYC    = RESET_CYC + 5 * DRAIN_CYC + 2 * (N_DIRECTED + N_RAND)
                               + MASK_CYC + N_PIPE;
  localparam int TIMEOUT_CYC = TEST_CYC + PIPE_LAT + 50;

  logic             clk;
  logic             rst_n;
  logic [REQ_W-1:0] req;
  logic             dir;
  logic             valid_in;
  logic             mask_wr;
  logic [REQ_W-1:0] mask_data;
  global_index_u    index;
  logic             hit;
  logic             valid_out;

  // Reference model
  logic [REQ_W-1:0]    model_mask;
  logic [GIDX_W:0]     exp_q[$];
  logic [GIDX_W:0]     exp_e;
  logic [PIPE_LAT-1:0] vin_hist;

  // Falling-edge copies compared by the assertions
  logic [GIDX_W-1:0] exp_flat;
  logic [GIDX_W-1:0] act_flat;
  logic [GIDX_W-1:0] prev_flat;
  logic              exp_hit;
  logic              act_hit;
  logic              prev_hit;
  logic              exp_vout;
  logic              act_vout;
  logic              chk_data;
  logic              chk_hold;

  int     err_cnt;
  int     chk_cnt;
  int     err_mark;
  int     chk_mark;
  int     test_cnt;
  int     test_fail_cnt;
  int     cycle_cnt = 0;
  string  test_name;
  integer seed;

  wide_prio_enc u_wide_prio_enc (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .dir       (dir),
    .valid_in  (valid_in),
    .mask_wr   (mask_wr),
    .mask_data (mask_data),
    .index     (index),
    .hit       (hit),
    .valid_out (valid_out)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Bit 0 is valid_in from the last rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vin_hist <= '0;
    end else begin
      vin_hist <= {vin_hist[PIPE_LAT-2:0], valid_in};
    end
  end

  // Outputs are stable between the rising edges
  always @(negedge clk) begin
    chk_data  = 1'b0;
    chk_hold  = 1'b0;
    prev_flat = act_flat;
    prev_hit  = act_hit;
    act_flat  = index.flat;
    act_hit   = hit;
    act_vout  = valid_out;
    exp_vout  = vin_hist[PIPE_LAT-1];
    if (rst_n) begin
      if (valid_out) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Test %s: a result came out with no request in flight", test_name);
        end else begin
          exp_e    = exp_q.pop_front();
          exp_hit  = exp_e[GIDX_W];
          exp_flat = exp_e[GIDX_W-1:0];
          chk_data = 1'b1;
          chk_cnt++;
        end
      end else begin
        chk_hold = 1'b1;
      end
    end
  end

  assert property (@(posedge clk) chk_data |-> (act_flat == exp_flat && act_hit == exp_hit))
    else begin
      err_cnt++;
      $display("FAILED %s: expected index %0d hit %0b, actual index %0d hit %0b",
               test_name, exp_flat, exp_hit, act_flat, act_hit);
    end

  // No valid result means index and hit keep their value
  assert property (@(posedge clk) chk_hold |-> (act_flat == prev_flat && act_hit == prev_hit))
    else begin
      err_cnt++;
      $display("FAILED %s hold: expected index %0d hit %0b, actual index %0d hit %0b",
               test_name, prev_flat, prev_hit, act_flat, act_hit);
    end

  assert property (@(posedge clk) disable iff (!rst_n) act_vout == exp_vout)
    else begin
      err_cnt++;
      $display("FAILED %s latency: expected valid_out %0b, actual valid_out %0b",
               test_name, exp_vout, act_vout);
    end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // The last set bit seen while scanning toward the preferred end wins
  function automatic logic [GIDX_W:0] find_winner(input logic [REQ_W-1:0] word,
                                                   input logic msb_first);
    logic [GIDX_W:0] res;
    res = '0;
    if (msb_first) begin
      for (int i = 0; i < REQ_W; i++) begin
        if (word[i]) res = {1'b1, GIDX_W'(i)};
      end
    end else begin
      for (int i = REQ_W - 1; i >= 0; i--) begin
        if (word[i]) res = {1'b1, GIDX_W'(i)};
      end
    end
    return res;
  endfunction

  // Lane edges, both word ends and a few multi-bit words
  function automatic logic [REQ_W-1:0] directed_word(input int n);
    case (n)
      0:       return 32'h0000_0001;
      1:       return 32'h8000_0000;
      2:       return 32'h0000_0100;
      3:       return 32'h0001_0000;
      4:       return 32'h0100_0000;
      5:       return 32'h8000_0001;
      6:       return 32'h0000_0006;
      7:       return 32'h0012_3400;
      8:       return 32'h8080_8080;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic send_req(input logic [REQ_W-1:0] word, input logic msb_first);
    @(negedge clk);
    req      = word;
    dir      = msb_first;
    valid_in = 1'b1;
    mask_wr  = 1'b0;
    exp_q.push_back(find_winner(word & model_mask, msb_first));
  endtask

  task automatic send_gap();
    @(negedge clk);
    req      = $random(seed);
    dir      = random_bit();
    valid_in = 1'b0;
    mask_wr  = 1'b0;
  endtask

  // A request sent with the write still sees the old mask
  task automatic write_mask(input logic [REQ_W-1:0] new_mask, input logic with_req,
                            input logic [REQ_W-1:0] word, input logic msb_first);
    @(negedge clk);
    mask_wr   = 1'b1;
    mask_data = new_mask;
    valid_in  = with_req;
    req       = word;
    dir       = msb_first;
    if (with_req) exp_q.push_back(find_winner(word & model_mask, msb_first));
    model_mask = new_mask;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = err_cnt;
    chk_mark  = chk_cnt;
  endtask

  task automatic finish_test();
    int errs;
    send_gap();
    while (exp_q.size() != 0) send_gap();
    send_gap();
    send_gap();
    errs = err_cnt - err_mark;
    test_cnt++;
    if (errs != 0) test_fail_cnt++;
    $display("Test %-10s %s, %0d results checked, %0d errors", test_name,
             (errs == 0) ? "ok" : "failed", chk_cnt - chk_mark, errs);
  endtask

  task automatic run_dir_test(input string name, input logic msb_first);
    start_test(name);
    for (int n = 0; n < N_DIRECTED; n++) send_req(directed_word(n), msb_first);
    for (int n = 0; n < N_RAND; n++) send_req($random(seed) & $random(seed), msb_first);
    finish_test();
  endtask

  initial begin
    logic [31:0] rnd;
    seed          = 32'h6109a2aa;
    err_cnt       = 0;
    chk_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    act_flat      = '0;
    act_hit       = 1'b0;
    chk_data      = 1'b0;
    chk_hold      = 1'b0;
    model_mask    = '1;
    rst_n         = 1'b0;
    req           = '0;
    dir           = 1'b0;
    valid_in      = 1'b0;
    mask_wr       = 1'b0;
    mask_data     = '0;

    start_test("reset");
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (RESET_CYC - 5) begin
      @(negedge clk);
      chk_cnt++;
      assert (valid_out == 1'b0 && hit == 1'b0 && index.flat == '0)
        else begin
          err_cnt++;
          $display("FAILED %s: expected valid_out 0 hit 0 index 0, actual %0b %0b %0d",
                   test_name, valid_out, hit, index.flat);
        end
      // Busy request lines without valid_in
      req = $random(seed);
      dir = random_bit();
    end
    finish_test();

    run_dir_test("lsb_first", 1'b0);
    run_dir_test("msb_first", 1'b1);

    start_test("masked");
    send_req('0, 1'b0);
    send_req('0, 1'b1);
    write_mask(32'h00FF_FF00, 1'b1, 32'h0000_0001, 1'b0);
    send_req(32'h0000_0001, 1'b0);
    send_req(32'hFF00_00FF, 1'b1);
    // Only bit 16 survives the mask
    send_req(32'h8001_0001, 1'b0);
    send_req(32'h8001_0001, 1'b1);
    send_req(32'hFFFF_FFFF, 1'b0);
    send_req(32'hFFFF_FFFF, 1'b1);
    for (int n = 0; n < 8; n++) send_req($random(seed), random_bit());
    write_mask('1, 1'b1, 32'h0000_00FF, 1'b1);
    send_req(32'h0000_00FF, 1'b1);
    finish_test();

    // Back-to-back traffic with about one gap in four
    start_test("pipeline");
    for (int n = 0; n < N_PIPE; n++) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        send_gap();
      end else begin
        send_req($random(seed) & $random(seed) & $random(seed), random_bit());
      end
    end
    finish_test();

    $display("Tests %0d, failed %0d, results checked %0d, errors %0d",
             test_cnt, test_fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && test_fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* wide_prio_enc.f */
enc_cfg_pkg.sv
enc_types_pkg.sv
req_mask_stage.sv
lane_prio_enc.sv
lane_result_merge.sv
wide_prio_enc.sv
wide_prio_enc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := wide_prio_enc_tb
DUT_TOP   := wide_prio_enc
FILELIST  := wide_prio_enc.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL TESTS PASSED
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
